//--- rtl/bpWidthsPkg.sv
package bpWidthsPkg;

    // fetch address in halfwords, i.e. the pc without bit 0.
    typedef logic [30:0] BranchAddr_t;

    // global branch history with the newest outcome in bit 0.
    typedef logic [15:0] BHist_t;

    typedef logic [1:0] TageID_t; // 0 is the base table, 1 and 2 are the tagged banks.

    // signed saturating counter, a negative value predicts not taken.
    typedef logic [2:0] TageCtr_t;

    typedef logic [1:0] BaseCtr_t; // bit 1 set means taken.

    typedef logic [7:0] TageTag_t;

endpackage

//--- rtl/bpMsgPkg.sv
package bpMsgPkg;

    import bpWidthsPkg::*;

    // prediction details that travel with the instruction to commit.
    typedef struct packed {
        logic predicted;
        logic taken;
        logic isJump;
        TageID_t tageID;
        logic tageUseful;
    } BranchPredInfo;

    // history restore from execute after a misprediction.
    typedef struct packed {
        logic taken;
        BHist_t history;
    } BranchProv;

    // target buffer write from an execute port.
    typedef struct packed {
        logic valid;
        BranchAddr_t src;
        BranchAddr_t dst;
        logic isJump;
        logic compr;
        logic clean; // drops the entry instead of writing it.
    } BTUpdate;

    // direction update at commit, with the history seen at prediction time.
    typedef struct packed {
        logic valid;
        BranchAddr_t pc;
        BHist_t history;
        logic branchTaken;
        BranchPredInfo bpi;
    } BPUpdate;

endpackage

//--- rtl/branchTargetBuffer.sv
`timescale 1ns/1ns

module branchTargetBuffer import bpWidthsPkg::*, bpMsgPkg::*; #(
    parameter int btbEntries = 32
) (
    input logic clk,
    input logic rst,
    input logic pcValid,
    input BranchAddr_t pc,
    input BTUpdate btUpdate,
    output logic branchFound,
    output BranchAddr_t branchSrc,
    output BranchAddr_t branchDst,
    output logic branchIsJump,
    output logic branchCompr,
    output logic multipleBranches
);

    localparam int idxBits = $clog2(btbEntries);

    typedef struct packed {
        BranchAddr_t src;
        BranchAddr_t dst;
        logic isJump;
        logic compr;
    } BtbEntry_t;

    logic [btbEntries-1:0] entryValid;
    BtbEntry_t entries [btbEntries];

    BranchAddr_t nextPc;
    logic [idxBits-1:0] idxLo;
    logic [idxBits-1:0] idxHi;
    logic [idxBits-1:0] writeIdx;
    logic hitLo;
    logic hitHi;

    logic lookupValid;
    logic hitReg;
    logic multiReg;
    BtbEntry_t hitEntry;

    assign nextPc = pc + 1'b1;
    assign idxLo = pc[idxBits-1:0];
    assign idxHi = nextPc[idxBits-1:0];
    assign writeIdx = btUpdate.src[idxBits-1:0];

    // the full source is compared, so aliasing entries never hit.
    assign hitLo = entryValid[idxLo] && (entries[idxLo].src == pc);

    // The second halfword only counts while it is in the same 32-bit word.
    assign hitHi = !pc[0] && entryValid[idxHi] && (entries[idxHi].src == nextPc);

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else if (btUpdate.valid) begin
            entryValid[writeIdx] <= !btUpdate.clean;
        end
    end

    always_ff @(posedge clk) begin
        if (btUpdate.valid && !btUpdate.clean) begin
            entries[writeIdx] <= '{btUpdate.src, btUpdate.dst, btUpdate.isJump, btUpdate.compr};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lookupValid <= 1'b0;
            hitReg <= 1'b0;
            multiReg <= 1'b0;
        end else begin
            lookupValid <= pcValid;
            if (pcValid) begin
                hitReg <= hitLo || hitHi;
                multiReg <= hitLo && hitHi;
            end
        end
    end

    // lower halfword wins when both are branches.
    always_ff @(posedge clk) begin
        if (pcValid) begin
            hitEntry <= hitLo ? entries[idxLo] : entries[idxHi];
        end
    end

    assign branchFound = lookupValid && hitReg; // found is only shown in the cycle after a lookup.
    assign multipleBranches = lookupValid && multiReg;
    assign branchSrc = hitEntry.src;
    assign branchDst = hitEntry.dst;
    assign branchIsJump = hitEntry.isJump;
    assign branchCompr = hitEntry.compr;

    // a shown hit belongs to the halfword that was looked up or the one after it.
    assert property (@(posedge clk) disable iff (rst)
        branchFound |-> $past(pcValid)
            && (branchSrc == $past(pc) || branchSrc == $past(nextPc)))
        else $error("BTB reports a hit for an address that was not looked up.");

endmodule

//--- rtl/tageTable.sv
`timescale 1ns/1ns

module tageTable import bpWidthsPkg::*; #(
    parameter int tageEntries = 64,
    parameter int histLen = 4
) (
    input logic clk,
    input logic rst,
    input BranchAddr_t lookupAddr,
    input BHist_t lookupHist,
    output logic hit,
    output TageCtr_t ctr,
    output logic useful,
    input logic writeUpdate,
    input logic writeAlloc,
    input BranchAddr_t writeAddr,
    input BHist_t writeHist,
    input logic writeTaken,
    input logic writeUseful,
    output logic writeFree
);

    localparam int idxBits = $clog2(tageEntries);
    localparam int tagBits = $bits(TageTag_t);

    typedef struct packed {
        TageTag_t tag;
        TageCtr_t ctr;
        logic useful;
    } TageEntry_t;

    logic [tageEntries-1:0] entryValid;
    TageEntry_t entries [tageEntries];

    logic [idxBits-1:0] lookupIdx;
    logic [idxBits-1:0] writeIdx;
    TageTag_t lookupTag;
    TageTag_t writeTag;
    TageCtr_t ctrNext;

    function automatic logic [idxBits-1:0] hashIdx(BranchAddr_t addr, BHist_t hist);
        logic [idxBits-1:0] acc;
        int i;
        acc = addr[idxBits-1:0];
        for (i = 0; i < histLen; i++) begin
            acc[i % idxBits] = acc[i % idxBits] ^ hist[i];
        end
        return acc;
    endfunction

    // history is folded in reversed here so index and tag don't alias the same way.
    function automatic TageTag_t hashTag(BranchAddr_t addr, BHist_t hist);
        TageTag_t acc;
        int i;
        acc = addr[idxBits +: tagBits];
        for (i = 0; i < histLen; i++) begin
            acc[(histLen - 1 - i) % tagBits] = acc[(histLen - 1 - i) % tagBits] ^ hist[i];
        end
        return acc;
    endfunction

    assign lookupIdx = hashIdx(lookupAddr, lookupHist);
    assign lookupTag = hashTag(lookupAddr, lookupHist);
    assign writeIdx = hashIdx(writeAddr, writeHist);
    assign writeTag = hashTag(writeAddr, writeHist);

    assign writeFree = !entryValid[writeIdx] || !entries[writeIdx].useful;

    always_comb begin
        ctrNext = entries[writeIdx].ctr;
        if (writeTaken && ctrNext != 3'b011) begin
            ctrNext = ctrNext + 1'b1;
        end else if (!writeTaken && ctrNext != 3'b100) begin
            ctrNext = ctrNext - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else if (writeAlloc) begin
            entryValid[writeIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (writeAlloc) begin
            // new entries start weak, 0 for taken and -1 for not taken.
            entries[writeIdx] <= '{writeTag, writeTaken ? 3'b000 : 3'b111, 1'b0};
        end else if (writeUpdate) begin
            entries[writeIdx].ctr <= ctrNext;
            entries[writeIdx].useful <= writeUseful;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
        end else begin
            hit <= entryValid[lookupIdx] && (entries[lookupIdx].tag == lookupTag);
        end
    end

    always_ff @(posedge clk) begin
        ctr <= entries[lookupIdx].ctr;
        useful <= entries[lookupIdx].useful;
    end

    assert property (@(posedge clk) disable iff (rst) !(writeUpdate && writeAlloc))
        else $error("TAGE bank got an update and an allocation together.");

endmodule

//--- rtl/tagePredictor.sv
`timescale 1ns/1ns

module tagePredictor import bpWidthsPkg::*; #(
    parameter int tageEntries = 64
) (
    input logic clk,
    input logic rst,
    input BranchAddr_t predAddr,
    input BHist_t predHistory,
    output TageID_t predTageID,
    output logic predUseful,
    output logic predTaken,
    input logic writeValid,
    input BranchAddr_t writeAddr,
    input BHist_t writeHistory,
    input TageID_t writeTageID,
    input logic writeTaken,
    input logic writeUseful,
    input logic writePred
);

    localparam int idxBits = $clog2(tageEntries);

    BaseCtr_t baseCtrs [tageEntries];
    BaseCtr_t baseCtr;
    BaseCtr_t baseNext;
    logic [idxBits-1:0] baseWriteIdx;

    logic hit1;
    logic hit2;
    TageCtr_t ctr1;
    TageCtr_t ctr2;
    logic free1;
    logic free2;

    logic update1;
    logic update2;
    logic alloc1;
    logic alloc2;
    logic mispred;
    logic usefulNext;

    assign baseWriteIdx = writeAddr[idxBits-1:0];

    always_comb begin
        baseNext = baseCtrs[baseWriteIdx];
        if (writeTaken && baseNext != 2'b11) begin
            baseNext = baseNext + 1'b1;
        end else if (!writeTaken && baseNext != 2'b00) begin
            baseNext = baseNext - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < tageEntries; i++) begin
                baseCtrs[i] <= 2'b01;
            end
            baseCtr <= 2'b01;
        end else begin
            baseCtr <= baseCtrs[predAddr[idxBits-1:0]];
            if (writeValid) begin
                baseCtrs[baseWriteIdx] <= baseNext; // base is trained on every update.
            end
        end
    end

    // the longest hitting bank provides, useful marks a provider that disagrees with its alternate.
    always_comb begin
        if (hit2) begin
            predTageID = 2'd2;
            predTaken = !ctr2[2];
            predUseful = !ctr2[2] != (hit1 ? !ctr1[2] : baseCtr[1]);
        end else if (hit1) begin
            predTageID = 2'd1;
            predTaken = !ctr1[2];
            predUseful = !ctr1[2] != baseCtr[1];
        end else begin
            predTageID = 2'd0;
            predTaken = baseCtr[1];
            predUseful = 1'b0;
        end
    end

    assign mispred = writePred != writeTaken;

    // A provider that mattered stays useful only while it is right.
    assign usefulNext = writeUseful && !mispred;

    assign update1 = writeValid && (writeTageID == 2'd1);
    assign update2 = writeValid && (writeTageID == 2'd2);

    // allocation goes to the first longer bank whose entry is free.
    assign alloc1 = writeValid && mispred && (writeTageID == 2'd0) && free1;
    assign alloc2 = writeValid && mispred && (writeTageID != 2'd2) && !alloc1 && free2;

    tageTable #(
        .tageEntries(tageEntries),
        .histLen(4)
    ) shortBank (
        .clk(clk),
        .rst(rst),
        .lookupAddr(predAddr),
        .lookupHist(predHistory),
        .hit(hit1),
        .ctr(ctr1),
        .useful(),
        .writeUpdate(update1),
        .writeAlloc(alloc1),
        .writeAddr(writeAddr),
        .writeHist(writeHistory),
        .writeTaken(writeTaken),
        .writeUseful(usefulNext),
        .writeFree(free1)
    );

    tageTable #(
        .tageEntries(tageEntries),
        .histLen(16)
    ) longBank (
        .clk(clk),
        .rst(rst),
        .lookupAddr(predAddr),
        .lookupHist(predHistory),
        .hit(hit2),
        .ctr(ctr2),
        .useful(),
        .writeUpdate(update2),
        .writeAlloc(alloc2),
        .writeAddr(writeAddr),
        .writeHist(writeHistory),
        .writeTaken(writeTaken),
        .writeUseful(usefulNext),
        .writeFree(free2)
    );

endmodule

//--- rtl/branchPredictor.sv
`timescale 1ns/1ns

module branchPredictor import bpWidthsPkg::*, bpMsgPkg::*; #(
    parameter int numIn = 2,
    parameter int btbEntries = 32,
    parameter int tageEntries = 64
) (
    input logic clk,
    input logic rst,
    input logic clearICache,
    input logic mispredFlush,
    input BranchProv branch,
    input logic pcValid,
    input logic [31:0] pc,
    output logic branchTaken,
    output logic isJump,
    output logic [31:0] branchSrc,
    output logic [31:0] branchDst,
    output BHist_t branchHistory,
    output BranchPredInfo branchInfo,
    output logic multipleBranches,
    output logic branchFound,
    output logic branchCompr,
    input BTUpdate btUpdates [numIn-1:0],
    input BPUpdate bpUpdate
);

    BHist_t gHistory;
    BHist_t gHistoryCom;
    BTUpdate btSel;
    BranchAddr_t btbSrc;
    BranchAddr_t btbDst;
    TageID_t tageID;
    logic tageUseful;
    logic tageTaken;
    logic tageWrite;

    // the highest valid port wins.
    always_comb begin
        btSel = '0;
        for (int i = 0; i < numIn; i++) begin
            if (btUpdates[i].valid) begin
                btSel = btUpdates[i];
            end
        end
    end

    branchTargetBuffer #(
        .btbEntries(btbEntries)
    ) btb (
        .clk(clk),
        .rst(rst || clearICache),
        .pcValid(pcValid),
        .pc(pc[31:1]),
        .btUpdate(btSel),
        .branchFound(branchFound),
        .branchSrc(btbSrc),
        .branchDst(btbDst),
        .branchIsJump(isJump),
        .branchCompr(branchCompr),
        .multipleBranches(multipleBranches)
    );

    assign tageWrite = bpUpdate.valid && bpUpdate.bpi.predicted && !mispredFlush;

    tagePredictor #(
        .tageEntries(tageEntries)
    ) tage (
        .clk(clk),
        .rst(rst),
        .predAddr(pc[31:1]),
        .predHistory(gHistory),
        .predTageID(tageID),
        .predUseful(tageUseful),
        .predTaken(tageTaken),
        .writeValid(tageWrite),
        .writeAddr(bpUpdate.pc),
        .writeHistory(bpUpdate.history),
        .writeTageID(bpUpdate.bpi.tageID),
        .writeTaken(bpUpdate.branchTaken),
        .writeUseful(bpUpdate.bpi.tageUseful),
        .writePred(bpUpdate.bpi.taken)
    );

    assign branchTaken = branchFound && (isJump || tageTaken);
    assign branchSrc = {btbSrc, 1'b0};
    assign branchDst = {btbDst, 1'b0};
    assign branchHistory = gHistory;

    always_comb begin
        branchInfo.predicted = branchFound;
        branchInfo.taken = branchTaken;
        branchInfo.isJump = isJump;
        branchInfo.tageID = tageID;
        branchInfo.tageUseful = tageUseful;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gHistory <= '0;
            gHistoryCom <= '0;
        end else begin
            // an execute restore beats a flush, which beats the speculative shift.
            if (branch.taken) begin
                gHistory <= branch.history;
            end else if (mispredFlush) begin
                gHistory <= gHistoryCom;
            end else if (branchFound && !isJump) begin
                gHistory <= {gHistory[$bits(BHist_t)-2:0], branchTaken};
            end

            if (bpUpdate.valid && !bpUpdate.bpi.isJump && !mispredFlush) begin
                gHistoryCom <= {gHistoryCom[$bits(BHist_t)-2:0], bpUpdate.branchTaken};
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) branchTaken |-> branchFound)
        else $error("taken prediction without a BTB hit.");

endmodule

//--- tests/branchPredictorTb.sv
`timescale 1ns/1ns

module branchPredictorTb import bpWidthsPkg::*, bpMsgPkg::*; ();

    localparam int numIn = 2;
    localparam int clkPeriod = 100;

    // expected lookup result as read from one L or S line.
    typedef struct packed {
        logic found;
        logic taken;
        logic jump;
        logic compr;
        logic multi;
        logic [31:0] src;
        logic [31:0] dst;
        TageID_t tid;
    } LookupExp_t;

    logic clk = 1'b0;
    logic rst;
    logic clearICache;
    logic mispredFlush;
    BranchProv branch;
    logic pcValid;
    logic [31:0] pc;
    BTUpdate btUpdates [numIn-1:0];
    BPUpdate bpUpdate;
    logic branchTaken;
    logic isJump;
    logic [31:0] branchSrc;
    logic [31:0] branchDst;
    BHist_t branchHistory;
    BranchPredInfo branchInfo;
    logic multipleBranches;
    logic branchFound;
    logic branchCompr;

    BHist_t expHist; // the testbench's own copy of the speculative history.
    logic [31:0] lfsrState = 32'hbffa_509c;
    int lineCount = 0;
    logic countDone = 1'b0;

    always #(clkPeriod / 2) clk = ~clk;

    branchPredictor #(
        .numIn(numIn),
        .btbEntries(32),
        .tageEntries(64)
    ) i_dut (
        .clk(clk),
        .rst(rst),
        .clearICache(clearICache),
        .mispredFlush(mispredFlush),
        .branch(branch),
        .pcValid(pcValid),
        .pc(pc),
        .branchTaken(branchTaken),
        .isJump(isJump),
        .branchSrc(branchSrc),
        .branchDst(branchDst),
        .branchHistory(branchHistory),
        .branchInfo(branchInfo),
        .multipleBranches(multipleBranches),
        .branchFound(branchFound),
        .branchCompr(branchCompr),
        .btUpdates(btUpdates),
        .bpUpdate(bpUpdate)
    );

    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBit(output logic b);
        lfsrState = lfsrNext(lfsrState);
        b = lfsrState[0];
    endtask

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("error at %0t ns: %s is %h, expected %h",
                              $time, name, actual, expected));
        end
    endtask

    task automatic targetUpdate(input logic [31:0] src, input logic [31:0] dst,
                                input logic jump, input logic compr, input logic clean);
        BTUpdate u;
        logic port;
        takeBit(port); // any execute port may deliver the target.
        u = '{1'b1, src[31:1], dst[31:1], jump, compr, clean};
        @(posedge clk);
        btUpdates[port] <= u;
        @(posedge clk);
        btUpdates[port] <= '0;
    endtask

    task automatic directionUpdate(input logic [31:0] addr, input BHist_t hist,
                                   input logic taken, input logic predTaken,
                                   input TageID_t tid, input logic useful);
        BPUpdate u;
        u = '0;
        u.valid = 1'b1;
        u.pc = addr[31:1];
        u.history = hist;
        u.branchTaken = taken;
        u.bpi = '{1'b1, predTaken, 1'b0, tid, useful};
        @(posedge clk);
        bpUpdate <= u;
        @(posedge clk);
        bpUpdate <= '0;
    endtask

    task automatic restoreHistory(input BHist_t hist);
        @(posedge clk);
        branch <= '{1'b1, hist};
        @(posedge clk);
        branch <= '0;
        expHist = hist;
    endtask

    task automatic clearBtb();
        @(posedge clk);
        clearICache <= 1'b1;
        @(posedge clk);
        clearICache <= 1'b0;
    endtask

    // restoreEn puts a restore on the edge where the found branch would shift in.
    task automatic runLookup(input logic [31:0] addr, input LookupExp_t e,
                             input logic restoreEn, input BHist_t restoreHist);
        @(posedge clk);
        pcValid <= 1'b1;
        pc <= addr;
        @(posedge clk);
        pcValid <= 1'b0;
        if (restoreEn) begin
            branch <= '{1'b1, restoreHist};
        end
        @(negedge clk);
        check("branchHistory", branchHistory, expHist);
        check("branchFound", branchFound, e.found);
        check("branchTaken", branchTaken, e.taken);
        check("multipleBranches", multipleBranches, e.multi);
        if (e.found) begin
            check("isJump", isJump, e.jump);
            check("branchCompr", branchCompr, e.compr);
            check("branchSrc", branchSrc, e.src);
            check("branchDst", branchDst, e.dst);
            if (!e.jump) begin
                check("branchInfo.tageID", branchInfo.tageID, e.tid);
                expHist = {expHist[$bits(BHist_t)-2:0], e.taken};
            end
        end
        if (restoreEn) begin
            @(posedge clk);
            branch <= '0;
            expHist = restoreHist; // the restore beats the shift.
            @(negedge clk);
            check("branchHistory", branchHistory, expHist);
        end
    endtask

    task automatic idleRandom();
        logic b0;
        logic b1;
        takeBit(b0);
        takeBit(b1);
        repeat ({b1, b0}) @(posedge clk);
    endtask

    initial begin
        wait (countDone);
        #(lineCount * 20 * clkPeriod + 4 * clkPeriod);
        failRun("the run timed out before the test file was finished");
    end

    initial begin
        int fd;
        int code;
        int c;
        logic done;
        logic [63:0] cmd;
        logic [31:0] f [10];
        LookupExp_t e;
        rst = 1'b1;
        clearICache = 1'b0;
        mispredFlush = 1'b0;
        branch = '0;
        pcValid = 1'b0;
        pc = '0;
        for (int i = 0; i < numIn; i++) begin
            btUpdates[i] = '0;
        end
        bpUpdate = '0;
        expHist = '0;

        fd = $fopen("tests/bpTests.txt", "r");
        if (fd == 0) begin
            failRun("cannot open tests/bpTests.txt");
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == 10) begin
                lineCount++;
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        countDone = 1'b1;
        fd = $fopen("tests/bpTests.txt", "r");

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                done = 1'b1;
            end else if (cmd == "#") begin
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end else begin
                case (cmd)
                    "T": begin
                        code = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                        if (code != 5) failRun("a T line in the test file is malformed");
                        targetUpdate(f[0], f[1], f[2][0], f[3][0], f[4][0]);
                    end
                    "L", "S": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                                       f[3], f[4], f[5], f[6], f[7], f[8]);
                        if (code != 9) failRun("a lookup line in the test file is malformed");
                        f[9] = '0;
                        if (cmd == "S") begin
                            code = $fscanf(fd, "%h", f[9]);
                        end
                        e = '{f[1][0], f[2][0], f[3][0], f[4][0], f[5][0], f[6], f[7],
                              f[8][1:0]};
                        runLookup(f[0], e, cmd == "S", f[9][15:0]);
                    end
                    "D": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                                       f[4], f[5]);
                        if (code != 6) failRun("a D line in the test file is malformed");
                        directionUpdate(f[0], f[1][15:0], f[2][0], f[3][0], f[4][1:0], f[5][0]);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h", f[0]);
                        restoreHistory(f[0][15:0]);
                    end
                    "C": clearBtb();
                    "I": begin
                        code = $fscanf(fd, "%h", f[0]);
                        repeat (f[0]) @(posedge clk);
                    end
                    default: failRun("the test file holds an unknown command");
                endcase
                idleRandom();
            end
        end
        $fclose(fd);
        repeat (2) @(posedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

//--- sim.f
rtl/bpWidthsPkg.sv
rtl/bpMsgPkg.sv
rtl/branchTargetBuffer.sv
rtl/tageTable.sv
rtl/tagePredictor.sv
rtl/branchPredictor.sv
tests/branchPredictorTb.sv

//--- tests/bpTests.txt
# L pc found taken jump compr multi src dst tageID, and S is L followed by a restore history
# T src dst jump compr clean, D pc hist taken predTaken tageID useful, R hist, C, I cycles
L 00005000 0 0 0 0 0 00000000 00000000 0
T 00001000 00002000 1 0 0
L 00001000 1 1 1 0 0 00001000 00002000 0
# same BTB index as the jump but another source
L 00005000 0 0 0 0 0 00000000 00000000 0
T 00001008 00002010 1 0 0
L 00001008 1 1 1 0 0 00001008 00002010 0
T 00001008 00000000 0 0 1
L 00001008 0 0 0 0 0 00000000 00000000 0
L 00001000 1 1 1 0 0 00001000 00002000 0
# conditional branch, the base counter says not taken
T 00001104 00001040 0 0 0
L 00001104 1 0 0 0 0 00001104 00001040 0
R 00a5
L 00001104 1 0 0 0 0 00001104 00001040 0
# mispredicted at commit, so the short bank gets an entry
D 00001104 00a5 1 0 0 0
R 00a5
L 00001104 1 1 0 0 0 00001104 00001040 1
# two branches in one word, the compressed jump is the lower one
T 00003210 00003400 1 1 0
T 00003212 00003000 0 0 0
L 00003210 1 1 1 1 1 00003210 00003400 0
L 00003212 1 0 0 0 0 00003212 00003000 0
I 2
C
L 00001000 0 0 0 0 0 00000000 00000000 0
L 00001104 0 0 0 0 0 00000000 00000000 0
L 00003210 0 0 0 0 0 00000000 00000000 0
# written again, the tagged entry still provides
T 00001104 00001040 0 0 0
R 00a5
L 00001104 1 1 0 0 0 00001104 00001040 1
R 00a5
S 00001104 1 1 0 0 0 00001104 00001040 1 0123
I 3
L 00003212 0 0 0 0 0 00000000 00000000 0
T 00001000 00002000 1 0 0
L 00001000 1 1 1 0 0 00001000 00002000 0
